//--- sources.f
rtl/core_pkg.sv
rtl/core_buses.sv
rtl/regfile.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/lsu.sv
rtl/wbu.sv
rtl/core_top.sv
sim/tb_core.sv

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam int COMMIT_TIMEOUT = 16;

    logic        clk;
    logic        rst_i;
    logic        imem_we_i;
    logic [7:0]  imem_addr_i;
    logic [31:0] imem_wdata_i;
    logic        commit_o;
    logic [31:0] pc_o;
    logic        rf_we_o;
    logic [4:0]  rf_waddr_o;
    logic [31:0] rf_wdata_o;
    logic        dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;

    logic [31:0] prog [$];
    int          exp_gap;
    int          store_count;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    core_top i_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .commit_o     (commit_o),
        .pc_o         (pc_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_wdata_o   (rf_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #20 clk = ~clk;
    end

    // Record every data memory write
    always @(negedge clk) begin
        if (dmem_we_o === 1'b1) begin
            store_count = store_count + 1;
            store_addr  = dmem_addr_o;
            store_data  = dmem_wdata_o;
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                           int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                           int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(OPC_OP_IMM, 3'b000, rd, rs1, imm);
    endfunction

    // SW only
    function automatic logic [31:0] s_type(int rs1, int rs2, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(int rd, logic [31:0] value);
        return {value[31:12], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic fail_now(string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else fail_now($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got,
                                exp));
    endtask

    task automatic check_quiet();
        assert (commit_o === 1'b0 && rf_we_o === 1'b0 && dmem_we_o === 1'b0)
        else fail_now($sformatf("error at %0d ns: commit_o %b rf_we_o %b dmem_we_o %b near reset",
                                $time, commit_o, rf_we_o, dmem_we_o));
    endtask

    // Reset the core with an optional program load and step past the quiet cycles
    task automatic start_program(bit load);
        @(posedge clk);
        #2;
        rst_i = 1'b1;
        if (load) begin
            for (int i = 0; i < prog.size(); i++) begin
                imem_we_i    = 1'b1;
                imem_addr_i  = 8'(i);
                imem_wdata_i = prog[i];
                @(posedge clk);
                #2;
            end
            imem_we_i = 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        check_quiet();
        @(posedge clk);
        #2;
        rst_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        exp_gap = 1;
    endtask

    task automatic wait_commit(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (commit_o !== 1'b1 && cycles < COMMIT_TIMEOUT);
        if (commit_o !== 1'b1) begin
            fail_now("Timed out waiting for an instruction to commit");
        end
    endtask

    task automatic expect_commit(logic [31:0] pc, bit check_wb, bit we, int rd,
                                 logic [31:0] data);
        int cycles;
        wait_commit(cycles);
        check_value("cycles to commit", cycles, exp_gap);
        exp_gap = 4;
        check_value("pc_o", pc_o, pc);
        if (check_wb) begin
            check_value("rf_we_o", 32'(rf_we_o), 32'(we));
            if (we) begin
                check_value("rf_waddr_o", 32'(rf_waddr_o), rd);
                check_value("rf_wdata_o", rf_wdata_o, data);
            end
        end
    endtask

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic push_li(int rd, logic [31:0] value);
        prog.push_back(u_type(rd, (value + 32'h800) & 32'hffff_f000));
        prog.push_back(addi(rd, rd, value));
    endtask

    task automatic expect_li(logic [31:0] pc, int rd, logic [31:0] value);
        expect_commit(pc, 1'b1, 1'b1, rd, (value + 32'h800) & 32'hffff_f000);
        expect_commit(pc + 4, 1'b1, 1'b1, rd, value);
    endtask

    task automatic alu_test(logic [31:0] a, logic [31:0] b, int imm);
        logic [31:0] imm_ext;
        imm_ext = {{20{imm[11]}}, imm[11:0]};
        prog.delete();
        push_li(1, a);
        push_li(2, b);
        prog.push_back(r_type(7'h00, 3'b000, 3, 1, 2));
        prog.push_back(r_type(7'h20, 3'b000, 4, 1, 2));
        prog.push_back(r_type(7'h00, 3'b111, 5, 1, 2));
        prog.push_back(r_type(7'h00, 3'b110, 6, 1, 2));
        prog.push_back(r_type(7'h00, 3'b100, 7, 1, 2));
        prog.push_back(r_type(7'h00, 3'b010, 8, 1, 2));
        prog.push_back(addi(9, 1, imm));
        prog.push_back(j_type(0, 0));
        start_program(1'b1);
        expect_li(0, 1, a);
        expect_li(8, 2, b);
        expect_commit(16, 1'b1, 1'b1, 3, a + b);
        expect_commit(20, 1'b1, 1'b1, 4, a - b);
        expect_commit(24, 1'b1, 1'b1, 5, a & b);
        expect_commit(28, 1'b1, 1'b1, 6, a | b);
        expect_commit(32, 1'b1, 1'b1, 7, a ^ b);
        expect_commit(36, 1'b1, 1'b1, 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_commit(40, 1'b1, 1'b1, 9, a + imm_ext);
    endtask

    task automatic zero_reg_test();
        prog.delete();
        prog.push_back(addi(5, 0, 77));
        prog.push_back(addi(0, 0, 123));
        prog.push_back(r_type(7'h00, 3'b000, 5, 0, 0));
        prog.push_back(addi(6, 5, 1));
        prog.push_back(j_type(0, 0));
        start_program(1'b1);
        expect_commit(0, 1'b1, 1'b1, 5, 77);
        expect_commit(4, 1'b0, 1'b0, 0, 0);
        expect_commit(8, 1'b1, 1'b1, 5, 0);
        expect_commit(12, 1'b1, 1'b1, 6, 1);
    endtask

    task automatic store_load_test();
        logic [31:0] addr;
        logic [31:0] value;
        addr  = ($urandom % 256) * 4;
        value = $urandom;
        prog.delete();
        push_li(1, addr);
        push_li(2, value);
        prog.push_back(s_type(1, 2, 0));
        prog.push_back(addi(3, 0, 0));
        prog.push_back(i_type(OPC_LOAD, 3'b010, 3, 1, 0));
        prog.push_back(j_type(0, 0));
        start_program(1'b1);
        store_count = 0;
        expect_li(0, 1, addr);
        expect_li(8, 2, value);
        expect_commit(16, 1'b1, 1'b0, 0, 0);
        check_value("store count", store_count, 1);
        check_value("dmem_addr_o", store_addr, addr);
        check_value("dmem_wdata_o", store_data, value);
        expect_commit(20, 1'b1, 1'b1, 3, 0);
        expect_commit(24, 1'b1, 1'b1, 3, value);
        check_value("store count", store_count, 1);
    endtask

    // Taken branches skip the ADDI x10 lines
    task automatic branch_test();
        prog.delete();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(addi(2, 0, 5));
        prog.push_back(addi(3, 0, 7));
        prog.push_back(b_type(3'b000, 1, 2, 8));
        prog.push_back(addi(10, 0, 1));
        prog.push_back(b_type(3'b001, 1, 3, 8));
        prog.push_back(addi(10, 0, 2));
        prog.push_back(b_type(3'b000, 1, 3, 8));
        prog.push_back(b_type(3'b001, 1, 2, 8));
        prog.push_back(j_type(0, 0));
        start_program(1'b1);
        expect_commit(0, 1'b1, 1'b1, 1, 5);
        expect_commit(4, 1'b1, 1'b1, 2, 5);
        expect_commit(8, 1'b1, 1'b1, 3, 7);
        expect_commit(12, 1'b1, 1'b0, 0, 0);
        expect_commit(20, 1'b1, 1'b0, 0, 0);
        expect_commit(28, 1'b1, 1'b0, 0, 0);
        expect_commit(32, 1'b1, 1'b0, 0, 0);
        expect_commit(36, 1'b0, 1'b0, 0, 0);
    endtask

    task automatic jal_test();
        prog.delete();
        prog.push_back(j_type(1, 12));
        prog.push_back(addi(7, 1, 0));
        prog.push_back(j_type(0, 0));
        prog.push_back(addi(3, 0, 33));
        prog.push_back(j_type(5, 8));
        prog.push_back(addi(10, 0, 1));
        prog.push_back(j_type(6, -20));
        start_program(1'b1);
        expect_commit(0, 1'b1, 1'b1, 1, 4);
        expect_commit(12, 1'b1, 1'b1, 3, 33);
        expect_commit(16, 1'b1, 1'b1, 5, 20);
        expect_commit(24, 1'b1, 1'b1, 6, 28);
        expect_commit(4, 1'b1, 1'b1, 7, 4);
        expect_commit(8, 1'b0, 1'b0, 0, 0);
        expect_commit(8, 1'b0, 1'b0, 0, 0);
    endtask

    // Second reset without a reload restarts the same program at 0
    task automatic reset_test();
        prog.delete();
        prog.push_back(addi(1, 0, 11));
        prog.push_back(addi(2, 1, 3));
        prog.push_back(j_type(0, 0));
        start_program(1'b1);
        expect_commit(0, 1'b1, 1'b1, 1, 11);
        expect_commit(4, 1'b1, 1'b1, 2, 14);
        start_program(1'b0);
        expect_commit(0, 1'b1, 1'b1, 1, 11);
        expect_commit(4, 1'b1, 1'b1, 2, 14);
    endtask

    initial begin
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        store_count  = 0;
        store_addr   = '0;
        store_data   = '0;
        exp_gap      = 1;
        void'($urandom(32'h82a2));

        reset_test();
        zero_reg_test();
        repeat (3) begin
            alu_test($urandom, $urandom, $urandom % 4096);
        end
        // Signed SLT corners
        alu_test(32'hffff_fff0, 32'h0000_0010, 12'h800);
        alu_test(32'h0000_0010, 32'hffff_fff0, 12'h7ff);
        alu_test(32'h8000_0000, 32'h7fff_ffff, 12'hfff);
        alu_test(32'hffff_fffe, 32'hffff_ffff, 12'h001);
        store_load_test();
        store_load_test();
        branch_test();
        jal_test();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             imem_we_i,
    input  logic [core_pkg::IMEM_ADDR_W-1:0] imem_addr_i,
    input  logic [core_pkg::XLEN-1:0]        imem_wdata_i,
    output logic                             commit_o,
    output logic [core_pkg::XLEN-1:0]        pc_o,
    output logic                             rf_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [core_pkg::XLEN-1:0]        rf_wdata_o,
    output logic                             dmem_we_o,
    output logic [core_pkg::XLEN-1:0]        dmem_addr_o,
    output logic [core_pkg::XLEN-1:0]        dmem_wdata_o
);

    logic                            issue;
    logic [core_pkg::XLEN-1:0]       fetch_pc;
    logic [core_pkg::XLEN-1:0]       fetch_inst;
    logic                            redirect;
    logic [core_pkg::XLEN-1:0]       target;
    logic                            pc_wen;
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();
    mem_wb_if u_mem_wb ();

    // PC of the instruction in flight, held until it retires
    assign pc_o = fetch_pc;

    regfile u_regfile (
        .clk      (clk),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we_o),
        .waddr_i  (rf_waddr_o),
        .wdata_i  (rf_wdata_o)
    );

    ifu u_ifu (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .pc_wen_i     (pc_wen),
        .redirect_i   (redirect),
        .target_i     (target),
        .issue_o      (issue),
        .pc_o         (fetch_pc),
        .inst_o       (fetch_inst)
    );

    idu u_idu (
        .issue_i    (issue),
        .pc_i       (fetch_pc),
        .inst_i     (fetch_inst),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .redirect_o (redirect),
        .target_o   (target),
        .ex         (u_id_ex.source)
    );

    exu u_exu (
        .clk   (clk),
        .rst_i (rst_i),
        .ex    (u_id_ex.sink),
        .mem   (u_ex_mem.source)
    );

    lsu u_lsu (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem          (u_ex_mem.sink),
        .wb           (u_mem_wb.source),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    // Writeback port doubles as the retirement trace
    wbu u_wbu (
        .wb         (u_mem_wb.sink),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o),
        .pc_wen_o   (pc_wen),
        .commit_o   (commit_o)
    );

endmodule

//--- rtl/wbu.sv
`timescale 1ns/1ps

module wbu (
    mem_wb_if.sink                          wb,
    output logic                            rf_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                            pc_wen_o,
    output logic                            commit_o
);

    // Load data or ALU result
    always_comb begin
        case (wb.wb_sel)
            core_pkg::WB_MEM: rf_wdata_o = wb.load_data;
            default:          rf_wdata_o = wb.result;
        endcase
    end

    assign rf_we_o    = wb.valid & wb.rf_we;
    assign rf_waddr_o = wb.rd;

    // Every valid instruction retires and releases the next fetch
    assign pc_wen_o = wb.valid;
    assign commit_o = wb.valid;

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                      clk,
    input  logic                      rst_i,
    ex_mem_if.sink                    mem,
    mem_wb_if.source                  wb,
    output logic                      dmem_we_o,
    output logic [core_pkg::XLEN-1:0] dmem_addr_o,
    output logic [core_pkg::XLEN-1:0] dmem_wdata_o
);

    logic [core_pkg::XLEN-1:0]               dmem [core_pkg::DMEM_DEPTH];
    logic [$clog2(core_pkg::DMEM_DEPTH)-1:0] word_idx;
    logic                                    ld_valid;
    logic [core_pkg::XLEN-1:0]               ld_result;
    logic [core_pkg::XLEN-1:0]               ld_data;
    logic [core_pkg::REG_ADDR_W-1:0]         ld_rd;
    logic                                    ld_rf_we;
    core_pkg::wb_sel_e                       ld_wb_sel;

    // Byte offset ignored, word access only
    assign word_idx     = mem.result[$clog2(core_pkg::DMEM_DEPTH)+1:2];
    assign dmem_we_o    = mem.valid & mem.mem_we;
    assign dmem_addr_o  = mem.result;
    assign dmem_wdata_o = mem.store_data;

    // Memory access stage
    always_ff @(posedge clk) begin
        if (dmem_we_o) begin
            dmem[word_idx] <= mem.store_data;
        end
        ld_data   <= dmem[word_idx];
        ld_result <= mem.result;
        ld_rd     <= mem.rd;
        ld_rf_we  <= mem.rf_we;
        ld_wb_sel <= mem.wb_sel;
    end

    // Output register toward writeback
    always_ff @(posedge clk) begin
        wb.result    <= ld_result;
        wb.load_data <= ld_data;
        wb.rd        <= ld_rd;
        wb.rf_we     <= ld_rf_we;
        wb.wb_sel    <= ld_wb_sel;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ld_valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            ld_valid <= mem.valid;
            wb.valid <= ld_valid;
        end
    end

endmodule

//--- rtl/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic     clk,
    input  logic     rst_i,
    id_ex_if.sink    ex,
    ex_mem_if.source mem
);

    logic [core_pkg::XLEN-1:0] alu_res;
    logic                      lt_signed;

    assign lt_signed = $signed(ex.op1) < $signed(ex.op2);

    always_comb begin
        case (ex.alu_op)
            core_pkg::ALU_ADD:    alu_res = ex.op1 + ex.op2;
            core_pkg::ALU_SUB:    alu_res = ex.op1 - ex.op2;
            core_pkg::ALU_AND:    alu_res = ex.op1 & ex.op2;
            core_pkg::ALU_OR:     alu_res = ex.op1 | ex.op2;
            core_pkg::ALU_XOR:    alu_res = ex.op1 ^ ex.op2;
            core_pkg::ALU_SLT:    alu_res = {{(core_pkg::XLEN-1){1'b0}}, lt_signed};
            core_pkg::ALU_PASS_B: alu_res = ex.op2;
            default:              alu_res = ex.op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem.valid <= 1'b0;
        end else begin
            mem.valid <= ex.valid;
        end
    end

    // Result and control carried along, qualified by valid
    always_ff @(posedge clk) begin
        mem.result     <= alu_res;
        mem.store_data <= ex.rs2_data;
        mem.rd         <= ex.rd;
        mem.rf_we      <= ex.rf_we;
        mem.mem_we     <= ex.mem_we;
        mem.wb_sel     <= ex.wb_sel;
    end

endmodule

//--- rtl/idu.sv
`timescale 1ns/1ps

module idu (
    input  logic                            issue_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    input  logic [core_pkg::XLEN-1:0]       inst_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_data_i,
    output logic                            redirect_o,
    output logic [core_pkg::XLEN-1:0]       target_o,
    id_ex_if.source                         ex
);

    core_pkg::opcode_e         opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;
    logic                      rs_eq;

    assign opcode     = core_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    assign rs_eq = (rs1_data_i == rs2_data_i);

    // Branch and jump targets share one adder
    assign target_o = pc_i + ((opcode == core_pkg::JAL) ? imm_j : imm_b);

    assign ex.valid    = issue_i;
    assign ex.rs2_data = rs2_data_i;
    assign ex.rd       = inst_i[11:7];

    // Defaults describe a no-op that still retires
    always_comb begin
        ex.op1     = rs1_data_i;
        ex.op2     = rs2_data_i;
        ex.alu_op  = core_pkg::ALU_ADD;
        ex.rf_we   = 1'b0;
        ex.mem_we  = 1'b0;
        ex.wb_sel  = core_pkg::WB_ALU;
        redirect_o = 1'b0;
        case (opcode)
            core_pkg::OP: begin
                ex.rf_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ex.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: ex.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_111: ex.alu_op = core_pkg::ALU_AND;
                    10'b0000000_110: ex.alu_op = core_pkg::ALU_OR;
                    10'b0000000_100: ex.alu_op = core_pkg::ALU_XOR;
                    10'b0000000_010: ex.alu_op = core_pkg::ALU_SLT;
                    default:         ex.rf_we  = 1'b0;
                endcase
            end
            core_pkg::OP_IMM: begin
                // ADDI only
                ex.op2   = imm_i;
                ex.rf_we = (funct3 == 3'b000);
            end
            core_pkg::LUI: begin
                ex.op1    = '0;
                ex.op2    = imm_u;
                ex.alu_op = core_pkg::ALU_PASS_B;
                ex.rf_we  = 1'b1;
            end
            core_pkg::LOAD: begin
                ex.op2    = imm_i;
                ex.rf_we  = (funct3 == 3'b010);
                ex.wb_sel = core_pkg::WB_MEM;
            end
            core_pkg::STORE: begin
                ex.op2    = imm_s;
                ex.mem_we = (funct3 == 3'b010);
            end
            core_pkg::BRANCH: begin
                case (funct3)
                    3'b000:  redirect_o = rs_eq;
                    3'b001:  redirect_o = !rs_eq;
                    default: redirect_o = 1'b0;
                endcase
            end
            core_pkg::JAL: begin
                // Link value is PC plus 4
                ex.op1     = pc_i;
                ex.op2     = core_pkg::XLEN'(4);
                ex.rf_we   = 1'b1;
                redirect_o = 1'b1;
            end
            default: begin
                ex.rf_we = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             imem_we_i,
    input  logic [core_pkg::IMEM_ADDR_W-1:0] imem_addr_i,
    input  logic [core_pkg::XLEN-1:0]        imem_wdata_i,
    input  logic                             pc_wen_i,
    input  logic                             redirect_i,
    input  logic [core_pkg::XLEN-1:0]        target_i,
    output logic                             issue_o,
    output logic [core_pkg::XLEN-1:0]        pc_o,
    output logic [core_pkg::XLEN-1:0]        inst_o
);

    logic [core_pkg::XLEN-1:0] imem [core_pkg::IMEM_DEPTH];
    logic [core_pkg::XLEN-1:0] pc_q;
    logic                      issue_q;

    // Program load, only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    // Issue pending out of reset, then once per retired instruction
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q    <= '0;
            issue_q <= 1'b1;
        end else begin
            issue_q <= pc_wen_i;
            if (pc_wen_i) begin
                pc_q <= redirect_i ? target_i : pc_q + core_pkg::XLEN'(4);
            end
        end
    end

    assign issue_o = issue_q;
    assign pc_o    = pc_q;
    // Word fetch at the current PC
    assign inst_o  = imem[pc_q[core_pkg::IMEM_ADDR_W+1:2]];

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i
);

    logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_ADDR_W];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads, x0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- rtl/core_buses.sv
`timescale 1ns/1ps

// Decode to execute
interface id_ex_if;
    logic                            valid;
    logic [core_pkg::XLEN-1:0]       op1;
    logic [core_pkg::XLEN-1:0]       op2;
    core_pkg::alu_op_e               alu_op;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic                            rf_we;
    logic                            mem_we;
    core_pkg::wb_sel_e               wb_sel;

    modport source (output valid, op1, op2, alu_op, rs2_data, rd, rf_we, mem_we, wb_sel);
    modport sink   (input  valid, op1, op2, alu_op, rs2_data, rd, rf_we, mem_we, wb_sel);
endinterface

// Execute to memory
interface ex_mem_if;
    logic                            valid;
    logic [core_pkg::XLEN-1:0]       result;
    logic [core_pkg::XLEN-1:0]       store_data;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic                            rf_we;
    logic                            mem_we;
    core_pkg::wb_sel_e               wb_sel;

    modport source (output valid, result, store_data, rd, rf_we, mem_we, wb_sel);
    modport sink   (input  valid, result, store_data, rd, rf_we, mem_we, wb_sel);
endinterface

// Memory to writeback
interface mem_wb_if;
    logic                            valid;
    logic [core_pkg::XLEN-1:0]       result;
    logic [core_pkg::XLEN-1:0]       load_data;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic                            rf_we;
    core_pkg::wb_sel_e               wb_sel;

    modport source (output valid, result, load_data, rd, rf_we, wb_sel);
    modport sink   (input  valid, result, load_data, rd, rf_we, wb_sel);
endinterface

//--- rtl/core_pkg.sv
package core_pkg;

    // Datapath and register file
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Word-indexed memories, address bits 9 to 2
    localparam int IMEM_DEPTH  = 256;
    localparam int DMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Writeback source
    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

endpackage
